// ==== Bender.yml ====
package:
  name: ifu

sources:
  - design/ifu_pkg.sv
  - design/fetch_fifo.sv
  - design/wb_fetch_master.sv
  - design/fetch_issue.sv
  - design/ifu_top.sv
  - target: simulation
    files:
      - bench/wb_inst_mem.sv
      - bench/tb_ifu.sv

// ==== bench/ifu_cases.txt ====
# name  command(run|redirect|freeze|stall)  cycles(decimal)  target_pc(hex)
# target_pc is used by redirect only
boot_run        run        60  00000000
stall_run       stall      80  00000000
jump_far        redirect   40  00001000
run_after_jump  run        40  00000000
freeze_short    freeze      6  00000000
resume_one      run        40  00000000
jump_back       redirect   40  00000040
stall_heavy     stall      60  00000000
freeze_long     freeze     30  00000000
resume_stall    stall      50  00000000
jump_early      redirect    4  00002000
jump_again      redirect   40  00000100
freeze_one      freeze      1  00000000
stall_jump      stall      30  00000000
jump_low        redirect   30  00000008
run_tail        run        50  00000000

// ==== bench/tb_ifu.sv ====
`timescale 1ns/1ns

module tb_ifu
  import ifu_pkg::*;
();

  localparam int          CLK_PERIOD = 20;
  localparam int          RST_CYCLES = 16;
  localparam int          MARGIN     = 200;
  localparam int          MAX_CASES  = 32;
  localparam word_t       INST_KEY   = 32'h13579bdf;
  localparam logic [31:0] SEED       = 32'h0dfeda01;

  logic        clk;
  logic        rst;
  alu_ctl_t    alu_ctl;
  wb_req_t     wb_req;
  wb_rsp_t     wb_rsp;
  fetch_out_t  fetch;
  logic        stall_en;
  logic [31:0] rnd;

  // case table from the file
  string case_name [MAX_CASES];
  string case_cmd  [MAX_CASES];
  int    case_cyc  [MAX_CASES];
  word_t case_pc   [MAX_CASES];
  int    n_cases;
  int    total_cyc;
  logic  cases_ready;
  logic  cases_ok;

  string cur_name;
  int    err_cnt;
  int    out_cnt;
  int    failed_tests;

  // reference model state
  word_t      exp_pc;
  int         in_flight;
  logic       have_last;
  word_t      last_adr;
  era_t       last_tgc;
  logic       after_rst;
  logic       frozen;
  logic       flush;
  logic       prev_frozen;
  logic       prev_flush;
  fetch_out_t prev_fetch;

  ifu_top UUT (
    .clk       ( clk ),
    .rst       ( rst ),
    .alu_ctl_i ( alu_ctl ),
    .wb_req_o  ( wb_req ),
    .wb_rsp_i  ( wb_rsp ),
    .fetch_o   ( fetch )
  );

  wb_inst_mem u_mem (
    .clk        ( clk ),
    .rst        ( rst ),
    .stall_en_i ( stall_en ),
    .rand_i     ( rnd ),
    .inst_key_i ( INST_KEY ),
    .wb_req_i   ( wb_req ),
    .wb_rsp_o   ( wb_rsp )
  );

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  initial
    begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
    end

  task automatic value_mismatch(input string what, input word_t exp, input word_t act);
    $display("[ERROR] %s: %s expected %h actual %h", cur_name, what, exp, act);
    err_cnt++;
  endtask

  task automatic log_fault(input string msg);
    $display("[ERROR] %s: %s", cur_name, msg);
    err_cnt++;
  endtask

  // inputs change 2 ns after the edge
  // one new random word per cycle
  task automatic next_cycle();
    @(posedge clk);
    #2;
    rnd = lcg_next(rnd);
  endtask

  task automatic load_cases(output logic ok);
    int    fd;
    int    n;
    string line;
    string nm;
    string cm;
    int    cy;
    word_t pc;
    ok = 1'b0;
    n_cases = 0;
    total_cyc = 0;
    fd = $fopen("bench/ifu_cases.txt", "r");
    if (fd != 0)
      begin
      while ($fgets(line, fd) != 0)
        begin
        n = $sscanf(line, "%s %s %d %h", nm, cm, cy, pc);
        // comment lines fail the scan or start with #
        if (n == 4 && nm.getc(0) != "#" && n_cases < MAX_CASES)
          begin
          case_name[n_cases] = nm;
          case_cmd[n_cases]  = cm;
          case_cyc[n_cases]  = cy;
          case_pc[n_cases]   = pc;
          total_cyc += cy;
          n_cases++;
          end
        end
      $fclose(fd);
      ok = (n_cases > 0);
      end
  endtask

  task automatic run_case(input int idx);
    int errs0;
    int outs0;
    errs0 = err_cnt;
    outs0 = out_cnt;
    cur_name = case_name[idx];
    stall_en = (case_cmd[idx] == "stall");
    if (case_cmd[idx] == "redirect")
      begin
      alu_ctl.vld     = 1'b1;
      alu_ctl.br_miss = 1'b1;
      alu_ctl.pc_next = case_pc[idx];
      end
    else if (case_cmd[idx] == "freeze")
      begin
      alu_ctl.vld    = 1'b1;
      alu_ctl.freeze = 1'b1;
      end
    else
      assert (case_cmd[idx] == "run" || case_cmd[idx] == "stall")
        else log_fault({"unknown command ", case_cmd[idx]});
    for (int i = 0; i < case_cyc[idx]; i++)
      begin
      next_cycle();
      // redirect is a single cycle pulse
      if (case_cmd[idx] == "redirect")
        alu_ctl = '0;
      end
    alu_ctl  = '0;
    stall_en = 1'b0;
    if (case_cmd[idx] == "run" || case_cmd[idx] == "stall")
      assert (out_cnt > outs0)
        else log_fault("no instruction was delivered during the test");
    if (err_cnt != errs0)
      failed_tests++;
    $display("test %s %s %0d cycles %0d fetches %s", cur_name, case_cmd[idx],
             case_cyc[idx], out_cnt - outs0, (err_cnt == errs0) ? "ok" : "FAILED");
  endtask

  initial
    begin
    rst          = 1'b1;
    alu_ctl      = '0;
    stall_en     = 1'b0;
    rnd          = SEED;
    cur_name     = "reset";
    err_cnt      = 0;
    out_cnt      = 0;
    failed_tests = 0;
    cases_ready  = 1'b0;
    load_cases(cases_ok);
    if (!cases_ok)
      $display("could not read any test case from bench/ifu_cases.txt");
    else
      begin
      cases_ready = 1'b1;
      repeat (RST_CYCLES) next_cycle();
      rst = 1'b0;
      for (int i = 0; i < n_cases; i++)
        run_case(i);
      end
    $display("%0d tests, %0d failed, %0d check errors, %0d fetches checked",
             n_cases, failed_tests, err_cnt, out_cnt);
    if (cases_ok && err_cnt == 0)
      $display("Simulation passed");
    else
      $display("Simulation failed");
    $finish;
    end

  // run length bound from the case file
  initial
    begin
    wait (cases_ready);
    #((total_cyc + RST_CYCLES + MARGIN) * CLK_PERIOD);
    $display("watchdog expired, the test sequence did not finish in time");
    $display("Simulation failed");
    $finish;
    end

  // reference checker at mid cycle when everything has settled
  always @(negedge clk)
    begin
    frozen = alu_ctl.vld & alu_ctl.freeze;
    flush  = alu_ctl.vld & alu_ctl.br_miss;
    // cyc follows stb in every cycle
    assert (wb_req.cyc == wb_req.stb)
      else log_fault("bus cyc differs from stb");
    if (rst)
      begin
      assert (wb_req.stb == 1'b0 && fetch.vld == 1'b0)
        else log_fault("stb or fetch valid high during reset");
      exp_pc    = RESET_PC;
      in_flight = 0;
      have_last = 1'b0;
      after_rst = 1'b1;
      end
    else
      begin
      if (after_rst)
        assert (wb_req.stb == 1'b0 && fetch.vld == 1'b0)
          else log_fault("stb or fetch valid high in the cycle after reset");
      after_rst = 1'b0;
      if (prev_flush)
        assert (fetch.vld == 1'b0) else log_fault("fetch valid high after a redirect");
      if (prev_frozen && !prev_flush)
        assert (fetch === prev_fetch) else log_fault("fetch output changed under freeze");
      // decoder takes the output when not frozen
      if (fetch.vld && !frozen)
        begin
        assert (fetch.pc == exp_pc) else value_mismatch("pc", exp_pc, fetch.pc);
        assert (fetch.inst == (exp_pc ^ INST_KEY))
          else value_mismatch("inst", exp_pc ^ INST_KEY, fetch.inst);
        exp_pc += INST_BYTES;
        out_cnt++;
        end
      if (flush)
        begin
        exp_pc    = alu_ctl.pc_next;
        have_last = 1'b0;
        end
      // accepted bus addresses step by 4 inside an era
      if (wb_req.stb && !wb_rsp.stall)
        begin
        if (have_last && wb_req.tgc == last_tgc)
          assert (wb_req.adr == last_adr + INST_BYTES)
            else value_mismatch("bus adr", last_adr + INST_BYTES, wb_req.adr);
        last_adr  = wb_req.adr;
        last_tgc  = wb_req.tgc;
        have_last = 1'b1;
        in_flight++;
        end
      if (wb_rsp.ack)
        in_flight--;
      assert (in_flight <= FIFO_DEPTH)
        else log_fault("more requests outstanding than the queue depth");
      end
    prev_fetch  = fetch;
    prev_frozen = frozen;
    prev_flush  = flush;
    end

endmodule

// ==== bench/wb_inst_mem.sv ====
`timescale 1ns/1ns

module wb_inst_mem
  import ifu_pkg::*;
(
  input  logic        clk,
  input  logic        rst,
  // random stall allowed this cycle
  input  logic        stall_en_i,
  // fresh random word every cycle
  input  logic [31:0] rand_i,
  // word at address a is a ^ inst_key_i
  input  word_t       inst_key_i,
  input  wb_req_t     wb_req_i,
  output wb_rsp_t     wb_rsp_o
);

  // one accepted request waiting for its ack
  typedef struct packed {
    word_t       adr;
    era_t        tgc;
    logic [31:0] due;
  } pend_t;

  pend_t       pend [$];
  pend_t       ent;
  wb_rsp_t     rsp;
  logic [31:0] cyc_cnt;

  always @(posedge clk)
    begin
    if (rst)
      begin
      pend.delete();
      cyc_cnt = '0;
      wb_rsp_o <= '0;
      end
    else
      begin
      // stb with stall low in the cycle just ended
      if (wb_req_i.stb & ~wb_rsp_o.stall)
        begin
        ent.adr = wb_req_i.adr;
        ent.tgc = wb_req_i.tgc;
        // 0 to 5 extra cycles of latency
        ent.due = cyc_cnt + 32'd1 + (rand_i[23:16] % 6);
        pend.push_back(ent);
        end
      cyc_cnt = cyc_cnt + 32'd1;
      rsp = '0;
      // strictly in order, a fast one waits behind a slow head
      if (pend.size() > 0 && pend[0].due <= cyc_cnt)
        begin
        ent = pend.pop_front();
        rsp.ack = 1'b1;
        rsp.dat = ent.adr ^ inst_key_i;
        rsp.tgc = ent.tgc;
        end
      rsp.stall = stall_en_i & rand_i[30];
      wb_rsp_o <= rsp;
      end
    end

endmodule

// ==== design/fetch_fifo.sv ====
`timescale 1ns/1ns

module fetch_fifo
  import ifu_pkg::*;
(
  input  logic  clk,
  input  logic  rst,
  // drop all entries at this edge
  input  logic  flush_i,
  input  logic  push_i,
  input  word_t data_i,
  input  logic  pop_i,
  // current head, valid when not empty
  output word_t data_o,
  output logic  full_o,
  output logic  empty_o
);

  // circular buffer storage
  word_t mem [FIFO_DEPTH];

  logic [$clog2(FIFO_DEPTH)-1:0] rd_ptr;
  logic [$clog2(FIFO_DEPTH)-1:0] wr_ptr;
  logic [FIFO_CNT_W-1:0]         count;

  logic do_push;
  logic do_pop;

  // flags straight off the occupancy count
  assign full_o  = (count == FIFO_CNT_W'(FIFO_DEPTH));
  assign empty_o = (count == '0);

  // ignore push when full and pop when empty
  assign do_push = push_i & ~full_o;
  assign do_pop  = pop_i & ~empty_o;

  // head word, read is combinational
  assign data_o = mem[rd_ptr];

  // pointers and count
  always_ff @(posedge clk)
    begin
    if (rst | flush_i)
      begin
      rd_ptr <= '0;
      wr_ptr <= '0;
      count  <= '0;
      end
    else
      begin
      // power of two depth, pointers wrap by themselves
      if (do_push)
        wr_ptr <= wr_ptr + 1'b1;
      if (do_pop)
        rd_ptr <= rd_ptr + 1'b1;

      // simultaneous push and pop leaves count alone
      case ({do_push, do_pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
      end
    end

  // write port
  always_ff @(posedge clk)
    begin
    if (do_push)
      mem[wr_ptr] <= data_i;
    end

endmodule

// ==== design/fetch_issue.sv ====
`timescale 1ns/1ns

module fetch_issue
  import ifu_pkg::*;
(
  input  logic       clk,
  input  logic       rst,
  // vld and freeze are used here
  input  alu_ctl_t   alu_ctl_i,
  input  logic       flush_i,

  // pc queue head
  input  logic       pc_empty_i,
  input  word_t      pc_head_i,

  // instruction queue head
  input  logic       inst_empty_i,
  input  word_t      inst_head_i,

  // one strobe pops both queues together
  output logic       pop_o,
  output fetch_out_t fetch_o
);

  logic  frozen;
  logic  pop;

  // registered decoder output
  logic  out_vld;
  word_t out_inst;
  word_t out_pc;

  // freeze counts only with a valid alu
  assign frozen = alu_ctl_i.vld & alu_ctl_i.freeze;

  // need a complete pair, no freeze, no redirect
  assign pop   = ~pc_empty_i & ~inst_empty_i & ~frozen & ~flush_i;
  assign pop_o = pop;

  // valid flag
  always_ff @(posedge clk)
    begin
    if (rst)
      out_vld <= 1'b0;
    else if (flush_i)
      // redirect kills whatever was on the output
      out_vld <= 1'b0;
    else if (~frozen)
      // underflow drops vld, a pop raises it
      out_vld <= pop;
    end

  // payload only moves on a pop, so it holds under freeze
  always_ff @(posedge clk)
    begin
    if (pop)
      begin
      out_inst <= inst_head_i;
      out_pc   <= pc_head_i;
      end
    end

  always_comb
    begin
    fetch_o.vld  = out_vld;
    fetch_o.inst = out_inst;
    fetch_o.pc   = out_pc;
    end

endmodule

// ==== design/ifu_pkg.sv ====
package ifu_pkg;

  // datapath width, addresses and instruction words
  localparam int XLEN = 32;

  // era tag width, carried on the bus as tgc
  localparam int ERA_W = 4;

  // queue geometry, same for the pc and the instruction queue
  localparam int FIFO_DEPTH = 8;
  // occupancy count, must hold 0..FIFO_DEPTH
  localparam int FIFO_CNT_W = 4;

  // fetch pc step, one 32-bit instruction
  localparam int INST_BYTES = 4;

  // one address or instruction word
  typedef logic [XLEN-1:0] word_t;

  // era tag, bumped on every redirect
  typedef logic [ERA_W-1:0] era_t;

  // first fetch address out of reset
  localparam word_t RESET_PC = '0;

  // pipelined wishbone request, master to slave
  typedef struct packed {
    logic  cyc;
    logic  stb;
    word_t adr;
    // era of the request
    era_t  tgc;
  } wb_req_t;

  // pipelined wishbone response, slave to master
  typedef struct packed {
    logic  ack;
    // slave not taking a request this cycle
    logic  stall;
    word_t dat;
    // era echoed back with the ack
    era_t  tgc;
  } wb_rsp_t;

  // feedback from the alu stage
  typedef struct packed {
    logic  vld;
    // hold the decoder output
    logic  freeze;
    // mispredict, redirect to pc_next
    logic  br_miss;
    word_t pc_next;
  } alu_ctl_t;

  // instruction and its pc towards the decoder
  typedef struct packed {
    logic  vld;
    word_t inst;
    word_t pc;
  } fetch_out_t;

endpackage

// ==== design/ifu_top.sv ====
`timescale 1ns/1ns

module ifu_top
  import ifu_pkg::*;
(
  input  logic       clk,
  input  logic       rst,
  input  alu_ctl_t   alu_ctl_i,
  output wb_req_t    wb_req_o,
  input  wb_rsp_t    wb_rsp_i,
  output fetch_out_t fetch_o
);

  // redirect on a valid branch miss
  logic  flush;

  // master to pc queue
  logic  pc_push;
  word_t pc_data;
  logic  pc_full;

  // master to instruction queue
  logic  inst_push;
  word_t inst_data;

  // queue heads towards the issue stage
  logic  pc_empty;
  word_t pc_head;
  logic  inst_empty;
  word_t inst_head;

  // joint pop from the issue stage
  logic  pop;

  assign flush = alu_ctl_i.vld & alu_ctl_i.br_miss;

  // fetch pc, era and bus side
  wb_fetch_master u_master (
    .clk         ( clk ),
    .rst         ( rst ),
    .alu_ctl_i   ( alu_ctl_i ),
    .flush_i     ( flush ),
    .pc_full_i   ( pc_full ),
    .wb_req_o    ( wb_req_o ),
    .wb_rsp_i    ( wb_rsp_i ),
    .pc_push_o   ( pc_push ),
    .pc_data_o   ( pc_data ),
    .inst_push_o ( inst_push ),
    .inst_data_o ( inst_data )
  );

  // issued addresses, its full flag throttles the bus
  fetch_fifo pc_fifo (
    .clk     ( clk ),
    .rst     ( rst ),
    .flush_i ( flush ),
    .push_i  ( pc_push ),
    .data_i  ( pc_data ),
    .pop_i   ( pop ),
    .data_o  ( pc_head ),
    .full_o  ( pc_full ),
    .empty_o ( pc_empty )
  );

  // returned words, never holds more entries than pc_fifo
  fetch_fifo inst_fifo (
    .clk     ( clk ),
    .rst     ( rst ),
    .flush_i ( flush ),
    .push_i  ( inst_push ),
    .data_i  ( inst_data ),
    .pop_i   ( pop ),
    .data_o  ( inst_head ),
    .full_o  ( ),
    .empty_o ( inst_empty )
  );

  // pairs heads and drives the decoder
  fetch_issue u_issue (
    .clk          ( clk ),
    .rst          ( rst ),
    .alu_ctl_i    ( alu_ctl_i ),
    .flush_i      ( flush ),
    .pc_empty_i   ( pc_empty ),
    .pc_head_i    ( pc_head ),
    .inst_empty_i ( inst_empty ),
    .inst_head_i  ( inst_head ),
    .pop_o        ( pop ),
    .fetch_o      ( fetch_o )
  );

endmodule

// ==== design/wb_fetch_master.sv ====
`timescale 1ns/1ns

module wb_fetch_master
  import ifu_pkg::*;
(
  input  logic     clk,
  input  logic     rst,
  // only pc_next is used here
  input  alu_ctl_t alu_ctl_i,
  // redirect, formed at the top level
  input  logic     flush_i,
  // pc queue has no room for another address
  input  logic     pc_full_i,

  output wb_req_t  wb_req_o,
  input  wb_rsp_t  wb_rsp_i,

  // accepted address into the pc queue
  output logic     pc_push_o,
  output word_t    pc_data_o,

  // returned word of the current era into the instruction queue
  output logic     inst_push_o,
  output word_t    inst_data_o
);

  // next address to request
  word_t fetch_pc;

  // current era, responses of older eras are dropped
  era_t era;

  // low during reset and for one cycle after
  logic issue_en;

  // requests accepted minus acks seen, across eras
  logic [FIFO_CNT_W-1:0] outstanding;

  logic room;
  logic req;
  logic accept;
  logic era_match;

  // old era responses still in flight after a flush count here too
  assign room = (outstanding != FIFO_CNT_W'(FIFO_DEPTH));

  // no request in the flush cycle, new era starts next cycle
  assign req = issue_en & ~pc_full_i & ~flush_i & room;

  // slave takes it when not stalling
  assign accept = req & ~wb_rsp_i.stall;

  // response tagged with the live era
  assign era_match = wb_rsp_i.ack & (wb_rsp_i.tgc == era);

  // bus request, held stable while stalled
  always_comb
    begin
    wb_req_o.cyc = req;
    wb_req_o.stb = req;
    wb_req_o.adr = fetch_pc;
    wb_req_o.tgc = era;
    end

  // address goes into the pc queue on the accepting edge
  assign pc_push_o = accept;
  assign pc_data_o = fetch_pc;

  // data of a stale era never reaches the queue
  // flush empties the queue at the same edge, so no push then either
  assign inst_push_o = era_match & ~flush_i;
  assign inst_data_o = wb_rsp_i.dat;

  always_ff @(posedge clk)
    begin
    if (rst)
      begin
      issue_en    <= 1'b0;
      fetch_pc    <= RESET_PC;
      era         <= '0;
      outstanding <= '0;
      end
    else
      begin
      issue_en <= 1'b1;

      // redirect wins over a normal step
      if (flush_i)
        begin
        fetch_pc <= alu_ctl_i.pc_next;
        era      <= era + 1'b1;
        end
      else if (accept)
        begin
        fetch_pc <= fetch_pc + word_t'(INST_BYTES);
        end

      // every ack retires one request, matching era or not
      case ({accept, wb_rsp_i.ack})
        2'b10:   outstanding <= outstanding + 1'b1;
        2'b01:   outstanding <= outstanding - 1'b1;
        default: outstanding <= outstanding;
      endcase
      end
    end

endmodule

// ==== tb.f ====
design/ifu_pkg.sv
design/fetch_fifo.sv
design/wb_fetch_master.sv
design/fetch_issue.sv
design/ifu_top.sv
bench/wb_inst_mem.sv
bench/tb_ifu.sv
